//--- bench/route_unit_tb.sv
`default_nettype none

`include "noc_route_consts.svh"

module route_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int N_REQ        = 421;  // 5 local, 320 sweep, 64 stall, 32 burst
    localparam int RSP_W        = `NOC_P + `NOC_CODE_W;
    localparam int STAY         = 0;
    localparam int PLUS         = 1;
    localparam int MINUS        = 2;
    localparam int CUR_X [4]    = '{0, 1, 3, 2};
    localparam int CUR_Y [4]    = '{0, 2, 3, 1};

    localparam noc_route_pkg::port_mask_t M_LOCAL = 5'b00001;
    localparam noc_route_pkg::port_mask_t M_EAST  = 5'b00010;
    localparam noc_route_pkg::port_mask_t M_NORTH = 5'b00100;
    localparam noc_route_pkg::port_mask_t M_WEST  = 5'b01000;
    localparam noc_route_pkg::port_mask_t M_SOUTH = 5'b10000;

    logic                      clk;
    logic                      rst_n;
    noc_route_pkg::x_coord_t   cur_x;
    noc_route_pkg::y_coord_t   cur_y;
    logic                      req_valid;
    logic                      req_ready;
    noc_route_pkg::x_coord_t   req_dest_x;
    noc_route_pkg::y_coord_t   req_dest_y;
    noc_route_pkg::algo_e      req_algo;
    logic                      rsp_valid;
    logic                      rsp_ready;
    noc_route_pkg::port_mask_t rsp_mask;
    noc_route_pkg::port_code_t rsp_code;

    logic [RSP_W-1:0] exp_q[$];     // expected {mask, code}, oldest first
    int               acc_q[$];     // cycle each request was taken
    string            test_name;
    int               cycle;
    int               last_stall;   // last edge with rsp_ready low
    int               n_acc;
    int               n_rsp;
    int               val_errs;
    int               other_errs;
    bit               held;
    logic [RSP_W-1:0] held_val;
    bit               stall_en;

    route_unit route_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_x      (cur_x),
        .cur_y      (cur_y),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_dest_x (req_dest_x),
        .req_dest_y (req_dest_y),
        .req_algo   (req_algo),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_mask   (rsp_mask),
        .rsp_code   (rsp_code)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // shortest way around one ring, 0 stay, 1 plus, 2 minus
    function automatic int ring_dir(input int c, input int d, input int n);
        int diff;
        diff = d - c;
        if (diff == 0) begin
            return STAY;
        end
        if (diff == 1 || diff == 1 - n || (c == n - 4 && d == n - 2) ||
            (c >= n - 2 && d <= n - 4) || (diff > 0 && d <= n - 3)) begin
            return PLUS;
        end
        return MINUS;
    endfunction

    function automatic logic [RSP_W-1:0] expect_rsp(input int cx, input int cy,
            input int dx, input int dy, input noc_route_pkg::algo_e algo);
        int                        hx;
        int                        hy;
        noc_route_pkg::port_mask_t xm;
        noc_route_pkg::port_mask_t ym;
        noc_route_pkg::port_mask_t m;
        noc_route_pkg::port_code_t c;
        hx = ring_dir(cx, dx, `NOC_NX);
        hy = ring_dir(cy, dy, `NOC_NY);
        xm = (hx == PLUS) ? M_EAST : (hx == MINUS) ? M_WEST : '0;
        ym = (hy == PLUS) ? M_SOUTH : (hy == MINUS) ? M_NORTH : '0;
        if (hx == STAY && hy == STAY) begin
            m = M_LOCAL;
        end else begin
            case (algo)
                noc_route_pkg::ALGO_WEST_FIRST: m = (hx == MINUS) ? xm : (xm | ym);
                noc_route_pkg::ALGO_NORTH_LAST: m = (xm != 0) ? (xm | (ym & ~M_NORTH)) : ym;
                noc_route_pkg::ALGO_NEG_FIRST: begin
                    if (hx == MINUS && hy == MINUS) m = xm;
                    else if (hx == PLUS && hy == PLUS) m = ym;
                    else m = xm | ym;
                end
                noc_route_pkg::ALGO_DUATO: m = xm | ym;
                default: m = (xm != 0) ? xm : ym;    // plain xy order
            endcase
        end
        c = {hx == PLUS, hy == PLUS, |(m & (M_EAST | M_WEST)), |(m & (M_NORTH | M_SOUTH))};
        return {m, c};
    endfunction

    // holds the request until the DUT takes it, returns one ns after that edge
    task automatic send_req(input int dx, input int dy, input int algo, input bit burst);
        bit taken;
        req_valid  = 1'b1;
        req_dest_x = noc_route_pkg::x_coord_t'(dx);
        req_dest_y = noc_route_pkg::y_coord_t'(dy);
        req_algo   = noc_route_pkg::algo_e'(algo);
        taken      = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = req_ready;
            if (burst) begin
                assert (taken) else begin
                    other_errs++;
                    $display("req_ready dropped during a back-to-back burst");
                end
            end
            #1;
        end
    endtask

    task automatic drain();
        req_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (exp_q.size() != 0);
    endtask

    always @(posedge clk) begin
        #1;
        rsp_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;  // stall about a third
    end

    always @(posedge clk) begin : monitor
        logic [RSP_W-1:0] exp_rsp;
        int               acc_cycle;
        cycle = cycle + 1;
        if (!rst_n || n_acc == 0) begin
            assert (!rsp_valid && req_ready) else begin
                other_errs++;
                $display("response side active before any request was accepted");
            end
        end
        if (rst_n) begin
            if (held) begin
                assert (rsp_valid && {rsp_mask, rsp_code} == held_val) else begin
                    val_errs++;
                    $display("[FAIL] %s: stalled response expected %h, actual %h",
                             test_name, held_val, {rsp_mask, rsp_code});
                end
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("response arrived with no request outstanding");
                end else begin
                    exp_rsp   = exp_q.pop_front();
                    acc_cycle = acc_q.pop_front();
                    n_rsp++;
                    assert ({rsp_mask, rsp_code} == exp_rsp) else begin
                        val_errs++;
                        $display("[FAIL] %s: mask/code expected %b/%b, actual %b/%b",
                                 test_name, exp_rsp[RSP_W-1 -: `NOC_P],
                                 exp_rsp[`NOC_CODE_W-1:0], rsp_mask, rsp_code);
                    end
                    if (last_stall <= acc_cycle) begin
                        assert (cycle - acc_cycle == 2) else begin
                            val_errs++;
                            $display("[FAIL] %s: latency expected 2, actual %0d",
                                     test_name, cycle - acc_cycle);
                        end
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(expect_rsp(cur_x, cur_y, req_dest_x, req_dest_y, req_algo));
                acc_q.push_back(cycle);
                n_acc++;
            end
        end
        if (!rsp_ready) last_stall = cycle;
        held     = rst_n && rsp_valid && !rsp_ready;
        held_val = {rsp_mask, rsp_code};
    end

    initial begin : watchdog
        #((RESET_CYCLES + N_REQ * 20) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int c;
        int a;
        int d;
        void'($urandom(32'h7e12_2476));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cur_x      = '0;
        cur_y      = '0;
        req_valid  = 1'b0;
        req_dest_x = '0;
        req_dest_y = '0;
        req_algo   = noc_route_pkg::ALGO_XY;
        rsp_ready  = 1'b1;
        stall_en   = 1'b0;
        test_name  = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;

        test_name = "local_dest";
        cur_x     = 2'd1;
        cur_y     = 2'd2;
        for (a = 0; a < 5; a++) send_req(1, 2, a, 1'b0);
        drain();

        for (c = 0; c < 4; c++) begin
            cur_x = noc_route_pkg::x_coord_t'(CUR_X[c]);   // only changed when drained
            cur_y = noc_route_pkg::y_coord_t'(CUR_Y[c]);
            for (a = 0; a < 5; a++) begin
                test_name = (a == 0) ? "xy_sweep" : "adaptive_sweep";
                for (d = 0; d < 16; d++) send_req(d % 4, d / 4, a, 1'b0);
                drain();
            end
        end

        test_name = "stall_random";
        cur_x     = 2'd2;
        cur_y     = 2'd1;
        stall_en  = 1'b1;
        repeat (64) send_req($urandom % 4, $urandom % 4, $urandom % 5, 1'b0);
        stall_en = 1'b0;
        drain();

        test_name = "back_to_back";
        for (d = 0; d < 32; d++) send_req(d % 4, (d / 4) % 4, d % 5, 1'b1);
        drain();

        repeat (3) @(posedge clk);
        assert (n_acc == n_rsp && n_acc == N_REQ) else begin
            other_errs++;
            $display("%0d requests accepted but %0d responses seen", n_acc, n_rsp);
        end
        $display("errors: %0d wrong values, %0d other; %0d requests, %0d responses",
                 val_errs, other_errs, n_acc, n_rsp);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/noc_route_pkg.sv
hw/torus_dir_if.sv
hw/torus_dir.sv
hw/route_select.sv
hw/pipe_reg.sv
hw/route_unit.sv
bench/route_unit_tb.sv

//--- hw/noc_route_consts.svh
`ifndef NOC_ROUTE_CONSTS_SVH
`define NOC_ROUTE_CONSTS_SVH

// torus grid size
`define NOC_NX      4
`define NOC_NY      4

// router address widths
`define NOC_X_W     2
`define NOC_Y_W     2

// signed width for the dest minus current difference
`define NOC_SX_W    4
`define NOC_SY_W    4

// local, east, north, west, south
`define NOC_P       5

// compact port code {x_plus, y_plus, horiz, vert}
`define NOC_CODE_W  4

`define NOC_ALGO_W  3

`endif

//--- hw/noc_route_pkg.sv
`default_nettype none

package noc_route_pkg;

`include "noc_route_consts.svh"

    typedef logic [`NOC_X_W-1:0]    x_coord_t;
    typedef logic [`NOC_Y_W-1:0]    y_coord_t;
    typedef logic [`NOC_P-1:0]      port_mask_t;    // indexed by port_idx_e
    typedef logic [`NOC_CODE_W-1:0] port_code_t;

    // routing class carried with each request
    typedef enum logic [`NOC_ALGO_W-1:0] {
        ALGO_XY,
        ALGO_WEST_FIRST,
        ALGO_NORTH_LAST,
        ALGO_NEG_FIRST,
        ALGO_DUATO
    } algo_e;

    // bit positions inside port_mask_t
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_idx_e;

endpackage

`default_nettype wire

//--- hw/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter int WIDTH = 8
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output logic      [WIDTH-1:0] out_data
);

    // free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // upstream holds a stalled input until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("pipe_reg: input changed while stalled");

endmodule

`default_nettype wire

//--- hw/route_select.sv
`default_nettype none

module route_select (
    input  wire noc_route_pkg::algo_e algo,
    torus_dir_if.dst                  dir,
    output noc_route_pkg::port_mask_t mask,
    output noc_route_pkg::port_code_t code
);

    noc_route_pkg::port_mask_t x_mask;      // horizontal hop, if any
    noc_route_pkg::port_mask_t y_mask;      // vertical hop, if any
    noc_route_pkg::port_mask_t duato_mask;
    noc_route_pkg::port_mask_t xy_mask;
    logic                      x_move;

    always_comb begin
        x_mask = '0;
        y_mask = '0;
        x_mask[noc_route_pkg::EAST]  = dir.x_plus;
        x_mask[noc_route_pkg::WEST]  = dir.x_min;
        y_mask[noc_route_pkg::SOUTH] = dir.y_plus;
        y_mask[noc_route_pkg::NORTH] = dir.y_min;
    end

    assign x_move     = dir.x_plus | dir.x_min;
    assign duato_mask = x_mask | y_mask;    // every minimal direction

    // dimension order, x resolved before y
    always_comb begin
        xy_mask = '0;
        if (dir.x_plus) begin
            xy_mask[noc_route_pkg::EAST] = 1'b1;
        end else if (dir.x_min) begin
            xy_mask[noc_route_pkg::WEST] = 1'b1;
        end else if (dir.y_plus) begin
            xy_mask[noc_route_pkg::SOUTH] = 1'b1;
        end else begin
            xy_mask[noc_route_pkg::NORTH] = 1'b1;
        end
    end

    always_comb begin
        mask = '0;
        if (dir.same_x && dir.same_y) begin
            mask[noc_route_pkg::LOCAL] = 1'b1;  // arrived, eject
        end else begin
            case (algo)
                noc_route_pkg::ALGO_WEST_FIRST: begin
                    // west hops must come first
                    mask = dir.x_min ? x_mask : duato_mask;
                end
                noc_route_pkg::ALGO_NORTH_LAST: begin
                    mask = duato_mask;
                    if (x_move) begin
                        mask[noc_route_pkg::NORTH] = 1'b0;  // north only at the end
                    end
                end
                noc_route_pkg::ALGO_NEG_FIRST: begin
                    if (dir.x_min && dir.y_min) begin
                        mask = x_mask;  // west before north
                    end else if (dir.x_plus && dir.y_plus) begin
                        mask = y_mask;  // south before east
                    end else begin
                        mask = duato_mask;
                    end
                end
                noc_route_pkg::ALGO_DUATO: mask = duato_mask;
                default:                   mask = xy_mask;
            endcase
        end
    end

    // {x_plus, y_plus, horizontal candidate, vertical candidate}
    assign code = {dir.x_plus,
                   dir.y_plus,
                   mask[noc_route_pkg::EAST] | mask[noc_route_pkg::WEST],
                   mask[noc_route_pkg::NORTH] | mask[noc_route_pkg::SOUTH]};

endmodule

`default_nettype wire

//--- hw/route_unit.sv
`default_nettype none

`include "noc_route_consts.svh"

module route_unit (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire noc_route_pkg::x_coord_t cur_x,    // static router address
    input  wire noc_route_pkg::y_coord_t cur_y,
    input  wire logic                    req_valid,
    output logic                         req_ready,
    input  wire noc_route_pkg::x_coord_t req_dest_x,
    input  wire noc_route_pkg::y_coord_t req_dest_y,
    input  wire noc_route_pkg::algo_e    req_algo,
    output logic                         rsp_valid,
    input  wire logic                    rsp_ready,
    output noc_route_pkg::port_mask_t    rsp_mask,
    output noc_route_pkg::port_code_t    rsp_code
);

    localparam int REQ_W = `NOC_X_W + `NOC_Y_W + `NOC_ALGO_W;
    localparam int RSP_W = `NOC_P + `NOC_CODE_W;

    logic [REQ_W-1:0]          req_q;       // {dest_x, dest_y, algo}
    logic                      req_q_valid;
    logic                      req_q_ready;
    noc_route_pkg::x_coord_t   dest_x_q;
    noc_route_pkg::y_coord_t   dest_y_q;
    noc_route_pkg::algo_e      algo_q;
    noc_route_pkg::port_mask_t sel_mask;
    noc_route_pkg::port_code_t sel_code;
    logic [RSP_W-1:0]          rsp_q;       // {mask, code}

    torus_dir_if dir_if ();

    pipe_reg #(.WIDTH(REQ_W)) req_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   ({req_dest_x, req_dest_y, req_algo}),
        .out_valid (req_q_valid),
        .out_ready (req_q_ready),
        .out_data  (req_q)
    );

    assign dest_x_q = req_q[REQ_W-1 -: `NOC_X_W];
    assign dest_y_q = req_q[`NOC_ALGO_W +: `NOC_Y_W];
    assign algo_q   = noc_route_pkg::algo_e'(req_q[`NOC_ALGO_W-1:0]);

    torus_dir torus_dir_inst (
        .cur_x  (cur_x),
        .cur_y  (cur_y),
        .dest_x (dest_x_q),
        .dest_y (dest_y_q),
        .dir    (dir_if.src)
    );

    route_select route_select_inst (
        .algo (algo_q),
        .dir  (dir_if.dst),
        .mask (sel_mask),
        .code (sel_code)
    );

    pipe_reg #(.WIDTH(RSP_W)) rsp_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_q_valid),
        .in_ready  (req_q_ready),
        .in_data   ({sel_mask, sel_code}),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp_q)
    );

    assign rsp_mask = rsp_q[RSP_W-1 -: `NOC_P];
    assign rsp_code = rsp_q[`NOC_CODE_W-1:0];

endmodule

`default_nettype wire

//--- hw/torus_dir.sv
`default_nettype none

`include "noc_route_consts.svh"

module torus_dir (
    input  wire noc_route_pkg::x_coord_t cur_x,
    input  wire noc_route_pkg::y_coord_t cur_y,
    input  wire noc_route_pkg::x_coord_t dest_x,
    input  wire noc_route_pkg::y_coord_t dest_y,
    torus_dir_if.src                     dir
);

    logic signed [`NOC_SX_W-1:0] xc;    // current
    logic signed [`NOC_SX_W-1:0] xd;    // destination
    logic signed [`NOC_SX_W-1:0] xdiff;
    logic signed [`NOC_SY_W-1:0] yc;
    logic signed [`NOC_SY_W-1:0] yd;
    logic signed [`NOC_SY_W-1:0] ydiff;
    logic                        x_fwd;
    logic                        y_fwd;

    assign xc    = {{(`NOC_SX_W-`NOC_X_W){1'b0}}, cur_x};
    assign xd    = {{(`NOC_SX_W-`NOC_X_W){1'b0}}, dest_x};
    assign yc    = {{(`NOC_SY_W-`NOC_Y_W){1'b0}}, cur_y};
    assign yd    = {{(`NOC_SY_W-`NOC_Y_W){1'b0}}, dest_y};
    assign xdiff = xd - xc;
    assign ydiff = yd - yc;

    // wrap-around rule, picks the plus direction on the ring
    assign x_fwd = (xdiff == 1) ||
                   (xdiff == (1 - `NOC_NX)) ||
                   ((xc == (`NOC_NX - 4)) && (xd == (`NOC_NX - 2))) ||
                   ((xc >= (`NOC_NX - 2)) && (xd <= (`NOC_NX - 4))) ||
                   ((xdiff > 0) && (xd <= (`NOC_NX - 3)));

    assign y_fwd = (ydiff == 1) ||
                   (ydiff == (1 - `NOC_NY)) ||
                   ((yc == (`NOC_NY - 4)) && (yd == (`NOC_NY - 2))) ||
                   ((yc >= (`NOC_NY - 2)) && (yd <= (`NOC_NY - 4))) ||
                   ((ydiff > 0) && (yd <= (`NOC_NY - 3)));

    always_comb begin
        dir.same_x = (xdiff == 0);
        dir.same_y = (ydiff == 0);
        dir.x_plus = x_fwd;
        dir.x_min  = !dir.same_x && !x_fwd;
        dir.y_plus = y_fwd;
        dir.y_min  = !dir.same_y && !y_fwd;
    end

    // each axis resolves to exactly one of stay, plus or minus
    always_comb begin
        if (!$isunknown({cur_x, cur_y, dest_x, dest_y})) begin
            assert ($onehot({dir.same_x, dir.x_plus, dir.x_min}))
                else $error("torus_dir: x direction not one-hot");
            assert ($onehot({dir.same_y, dir.y_plus, dir.y_min}))
                else $error("torus_dir: y direction not one-hot");
        end
    end

endmodule

`default_nettype wire

//--- hw/torus_dir_if.sv
`default_nettype none

interface torus_dir_if;

    logic x_plus;   // go east, shortest way around the ring
    logic x_min;    // go west
    logic y_plus;   // go south
    logic y_min;    // go north
    logic same_x;
    logic same_y;

    modport src (
        output x_plus, x_min, y_plus, y_min, same_x, same_y
    );

    modport dst (
        input x_plus, x_min, y_plus, y_min, same_x, same_y
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the route_unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module route_unit_tb -f files.f -o route_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/route_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$log"; then
    exit 1
fi
exit 0
